/* source/bus_types_pkg.sv */
package bus_types_pkg;

    typedef logic [63:0] addr_t;       // byte address
    typedef logic [63:0] dword_t;      // bus data
    typedef logic [8:0]  word_idx_t;   // doubleword index into RAM
    typedef logic [2:0]  byte_off_t;   // byte within a doubleword
    typedef logic [7:0]  byte_en_t;    // one bit per RAM lane
    typedef logic [4:0]  irq_id_t;
    typedef logic [2:0]  prio_t;       // priority or threshold

    // codes as the CPU issues them, stores use the first four
    typedef enum logic [2:0] {
        LS_B  = 3'd0,
        LS_H  = 3'd1,
        LS_W  = 3'd2,
        LS_D  = 3'd3,
        LS_BU = 3'd4,
        LS_HU = 3'd5,
        LS_WU = 3'd6
    } ls_type_e;

    typedef enum logic [3:0] {
        TGT_NONE,
        TGT_RAM,
        TGT_MTIMECMP,
        TGT_PRIORITY,
        TGT_PENDING,
        TGT_ENABLE0,
        TGT_ENABLE1,
        TGT_THRESH0,
        TGT_THRESH1,
        TGT_CLAIM0,
        TGT_CLAIM1
    } target_e;

endpackage

/* source/bus_map_pkg.sv */
package bus_map_pkg;

    // on-chip RAM window
    localparam logic [63:0] RAM_BASE = 64'h0000_0000_8000_0000;
    localparam logic [63:0] RAM_SIZE = 64'd4096;                   // bytes

    // machine timer compare, mtime itself lives in the CPU
    localparam logic [63:0] MTIMECMP_ADDR  = 64'h0000_0000_0200_4000;
    localparam logic [63:0] MTIMECMP_RESET = 64'h0000_0000_8000_0000;

    // interrupt controller
    localparam logic [63:0] PLIC_BASE        = 64'h0000_0000_0C00_0000;
    localparam logic [63:0] PLIC_PRIO_STRIDE = 64'd4;              // one word per id
    localparam int          PLIC_NUM_SOURCES = 5;                  // ids 1 to 5

    localparam logic [63:0] PLIC_PENDING = 64'h0000_0000_0C00_1000;

    localparam logic [63:0] PLIC_ENABLE            = 64'h0000_0000_0C00_2000;
    localparam logic [63:0] PLIC_CTX_ENABLE_STRIDE = 64'h80;

    // threshold and claim repeat per context
    localparam logic [63:0] PLIC_THRESHOLD  = 64'h0000_0000_0C20_0000;
    localparam logic [63:0] PLIC_CLAIM      = 64'h0000_0000_0C20_0004;
    localparam logic [63:0] PLIC_CTX_STRIDE = 64'h1000;

    // only wired source, stands in for the uart line
    localparam int PLIC_SOURCE_ID = 1;

endpackage

/* source/decoded_req_if.sv */
interface decoded_req_if
    import bus_types_pkg::*;
();
    logic      valid;      // one cycle per request
    logic      is_write;
    target_e   target;
    word_idx_t word_idx;
    byte_off_t byte_off;
    irq_id_t   irq_id;     // only meaningful for priority accesses
    ls_type_e  ls_type;
    dword_t    wdata;

    modport stage1 (
        output valid, is_write, target, word_idx,
        output byte_off, irq_id, ls_type, wdata
    );

    modport stage2 (
        input valid, is_write, target, word_idx,
        input byte_off, irq_id, ls_type, wdata
    );

endinterface

/* source/access_rsp_if.sv */
interface access_rsp_if
    import bus_types_pkg::*;
();
    logic      valid;
    logic      is_write;
    dword_t    rdata;      // raw doubleword, not yet aligned
    byte_off_t byte_off;
    ls_type_e  ls_type;

    modport stage2 (
        output valid, is_write, rdata, byte_off, ls_type
    );

    modport stage3 (
        input valid, is_write, rdata, byte_off, ls_type
    );

endinterface

/* source/ram_bank.sv */
module ram_bank
    import bus_types_pkg::*;
(
    input  logic      CLOCK_50,
    input  logic      we,
    input  byte_en_t  be,
    input  word_idx_t addr,
    input  dword_t    wdata,
    output dword_t    rdata
);
    localparam int LANES = $bits(byte_en_t);
    localparam int DEPTH = 2 ** $bits(word_idx_t);

    dword_t mem [DEPTH];

    // read returns the old contents when the same word is written
    always_ff @(posedge CLOCK_50) begin
        rdata <= mem[addr];
        if (we) begin
            for (int lane = 0; lane < LANES; lane++) begin
                if (be[lane])
                    mem[addr][lane*8 +: 8] <= wdata[lane*8 +: 8];
            end
        end
    end

endmodule

/* source/plic.sv */
module plic
    import bus_types_pkg::*;
#(
    parameter int SOURCE_ID   = 1,
    parameter int NUM_SOURCES = 5
) (
    input  logic    CLOCK_50,
    input  logic    KEY0,
    input  logic    ext_irq,
    input  target_e sel,
    input  irq_id_t irq_id,
    input  logic    rd,
    input  logic    wr,
    input  dword_t  wdata,
    output dword_t  rdata,
    output logic    meip_interrupt,
    output logic    seip_interrupt
);
    prio_t       prio [1:NUM_SOURCES];
    logic [31:0] pending;
    logic [31:0] enable [2];   // context 0 machine, 1 supervisor
    prio_t       thresh [2];   // stored only, no gating
    irq_id_t     claim [2];
    logic        irq_q;
    logic        irq_rise;
    logic        claim_taken;

    assign irq_rise = ext_irq & ~irq_q;

    always_comb begin
        for (int c = 0; c < 2; c++) begin
            if (pending[SOURCE_ID] && enable[c][SOURCE_ID])
                claim[c] = irq_id_t'(SOURCE_ID);
            else
                claim[c] = '0;
        end
    end

    assign meip_interrupt = claim[0] != '0;
    assign seip_interrupt = claim[1] != '0;

    assign claim_taken = rd && ((sel == TGT_CLAIM0 && meip_interrupt) ||
                                (sel == TGT_CLAIM1 && seip_interrupt));

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            for (int i = 1; i <= NUM_SOURCES; i++)
                prio[i] <= '0;
            pending   <= '0;
            enable[0] <= '0;
            enable[1] <= '0;
            thresh[0] <= '0;
            thresh[1] <= '0;
            irq_q     <= 1'b0;
        end else begin
            irq_q <= ext_irq;
            if (claim_taken)
                pending[SOURCE_ID] <= 1'b0;
            if (irq_rise)
                pending[SOURCE_ID] <= 1'b1;   // new edge wins over a claim
            if (wr) begin
                case (sel)
                    TGT_PRIORITY: prio[irq_id] <= wdata[2:0];
                    TGT_ENABLE0:  enable[0] <= wdata[31:0];
                    TGT_ENABLE1:  enable[1] <= wdata[31:0];
                    TGT_THRESH0:  thresh[0] <= wdata[2:0];
                    TGT_THRESH1:  thresh[1] <= wdata[2:0];
                    default: ;                 // pending and claim are read only
                endcase
            end
        end
    end

    // registered read port
    always_ff @(posedge CLOCK_50) begin
        if (rd) begin
            case (sel)
                TGT_PRIORITY: rdata <= dword_t'(prio[irq_id]);
                TGT_PENDING:  rdata <= dword_t'(pending);
                TGT_ENABLE0:  rdata <= dword_t'(enable[0]);
                TGT_ENABLE1:  rdata <= dword_t'(enable[1]);
                TGT_THRESH0:  rdata <= dword_t'(thresh[0]);
                TGT_THRESH1:  rdata <= dword_t'(thresh[1]);
                TGT_CLAIM0:   rdata <= dword_t'(claim[0]);
                TGT_CLAIM1:   rdata <= dword_t'(claim[1]);
                default:      rdata <= '0;
            endcase
        end
    end

endmodule

/* source/address_decode.sv */
module address_decode
    import bus_types_pkg::*;
    import bus_map_pkg::*;
(
    input  logic          CLOCK_50,
    input  logic          KEY0,
    input  addr_t         bus_address,
    input  dword_t        bus_write_data,
    input  ls_type_e      bus_ls_type,
    input  logic          bus_read_enable,
    input  logic          bus_write_enable,
    decoded_req_if.stage1 req
);
    addr_t   plic_off;
    target_e target;
    logic    strobe;

    assign strobe   = bus_read_enable | bus_write_enable;
    assign plic_off = bus_address - PLIC_BASE;   // wraps large below the base

    always_comb begin
        target = TGT_NONE;
        if (bus_address >= RAM_BASE && bus_address < RAM_BASE + RAM_SIZE) begin
            target = TGT_RAM;
        end else if (bus_address == MTIMECMP_ADDR) begin
            target = TGT_MTIMECMP;
        end else if (plic_off >= PLIC_PRIO_STRIDE && plic_off[1:0] == 2'b00 &&
                     plic_off <= PLIC_PRIO_STRIDE * PLIC_NUM_SOURCES) begin
            target = TGT_PRIORITY;                 // id 0 stays unmapped
        end else if (bus_address == PLIC_PENDING) begin
            target = TGT_PENDING;
        end else if (bus_address == PLIC_ENABLE) begin
            target = TGT_ENABLE0;
        end else if (bus_address == PLIC_ENABLE + PLIC_CTX_ENABLE_STRIDE) begin
            target = TGT_ENABLE1;
        end else if (bus_address == PLIC_THRESHOLD) begin
            target = TGT_THRESH0;
        end else if (bus_address == PLIC_THRESHOLD + PLIC_CTX_STRIDE) begin
            target = TGT_THRESH1;
        end else if (bus_address == PLIC_CLAIM) begin
            target = TGT_CLAIM0;
        end else if (bus_address == PLIC_CLAIM + PLIC_CTX_STRIDE) begin
            target = TGT_CLAIM1;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            req.valid <= 1'b0;
        end else begin
            req.valid <= strobe;     // high for one cycle only
        end
    end

    // request fields, captured with the strobe
    always_ff @(posedge CLOCK_50) begin
        if (strobe) begin
            req.is_write <= bus_write_enable;
            req.target   <= target;
            req.word_idx <= bus_address[3 +: $bits(word_idx_t)];
            req.byte_off <= bus_address[2:0];
            req.irq_id   <= plic_off[2 +: $bits(irq_id_t)];   // offset / 4
            req.ls_type  <= bus_ls_type;
            req.wdata    <= bus_write_data;
        end
    end

endmodule

/* source/access_stage.sv */
module access_stage
    import bus_types_pkg::*;
    import bus_map_pkg::*;
(
    input  logic          CLOCK_50,
    input  logic          KEY0,
    input  logic          ext_irq,
    decoded_req_if.stage2 req,
    access_rsp_if.stage2  rsp,
    output logic          meip_interrupt,
    output logic          seip_interrupt
);
    byte_en_t be;
    dword_t   ram_wdata;
    dword_t   ram_rdata;
    dword_t   plic_rdata;
    dword_t   mtimecmp;
    logic     store;
    logic     load;
    logic     ram_we;
    target_e  rsp_target;     // picks the rdata source in the next cycle

    assign store  = req.valid & req.is_write;
    assign load   = req.valid & ~req.is_write;
    assign ram_we = store && req.target == TGT_RAM;

    // lane enables and replicated store data for aligned accesses
    always_comb begin
        case (req.ls_type)
            LS_B: begin
                be        = byte_en_t'(8'h01 << req.byte_off);
                ram_wdata = {8{req.wdata[7:0]}};
            end
            LS_H: begin
                be        = byte_en_t'(8'h03 << req.byte_off);
                ram_wdata = {4{req.wdata[15:0]}};
            end
            LS_W: begin
                be        = byte_en_t'(8'h0f << req.byte_off);
                ram_wdata = {2{req.wdata[31:0]}};
            end
            LS_D: begin
                be        = 8'hff;
                ram_wdata = req.wdata;
            end
            default: begin
                be        = '0;          // nothing written without a store width
                ram_wdata = req.wdata;
            end
        endcase
    end

    ram_bank i_ram_bank (
        .CLOCK_50 (CLOCK_50),
        .we       (ram_we),
        .be       (be),
        .addr     (req.word_idx),
        .wdata    (ram_wdata),
        .rdata    (ram_rdata)
    );

    plic #(
        .SOURCE_ID   (PLIC_SOURCE_ID),
        .NUM_SOURCES (PLIC_NUM_SOURCES)
    ) i_plic (
        .CLOCK_50       (CLOCK_50),
        .KEY0           (KEY0),
        .ext_irq        (ext_irq),
        .sel            (req.target),
        .irq_id         (req.irq_id),
        .rd             (load),
        .wr             (store),
        .wdata          (req.wdata),
        .rdata          (plic_rdata),
        .meip_interrupt (meip_interrupt),
        .seip_interrupt (seip_interrupt)
    );

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            mtimecmp  <= MTIMECMP_RESET;
            rsp.valid <= 1'b0;
        end else begin
            rsp.valid <= req.valid;
            if (store && req.target == TGT_MTIMECMP)
                mtimecmp <= req.wdata;     // whole register regardless of width
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (req.valid) begin
            rsp.is_write <= req.is_write;
            rsp.byte_off <= req.byte_off;
            rsp.ls_type  <= req.ls_type;
            rsp_target   <= req.target;
        end
    end

    // ram and plic outputs are already registered
    always_comb begin
        case (rsp_target)
            TGT_RAM:      rsp.rdata = ram_rdata;
            TGT_MTIMECMP: rsp.rdata = mtimecmp;
            TGT_NONE:     rsp.rdata = '0;   // unmapped load reads zero
            default:      rsp.rdata = plic_rdata << {rsp.byte_off[2], 5'b00000};  // word in its half
        endcase
    end

endmodule

/* source/load_align.sv */
module load_align
    import bus_types_pkg::*;
(
    input  logic         CLOCK_50,
    input  logic         KEY0,
    input  logic         req_valid,
    input  logic         req_is_write,
    access_rsp_if.stage3 rsp,
    output dword_t       bus_read_data,
    output logic         bus_read_done,
    output logic         bus_write_done
);
    dword_t shifted;
    dword_t extended;

    // move the addressed bytes down to bit 0
    assign shifted = rsp.rdata >> {rsp.byte_off, 3'b000};

    always_comb begin
        case (rsp.ls_type)
            LS_B:    extended = {{56{shifted[7]}}, shifted[7:0]};
            LS_H:    extended = {{48{shifted[15]}}, shifted[15:0]};
            LS_W:    extended = {{32{shifted[31]}}, shifted[31:0]};
            LS_BU:   extended = {56'b0, shifted[7:0]};
            LS_HU:   extended = {48'b0, shifted[15:0]};
            LS_WU:   extended = {32'b0, shifted[31:0]};
            default: extended = shifted;     // doubleword
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bus_read_data  <= '0;
            bus_read_done  <= 1'b1;
            bus_write_done <= 1'b1;
        end else begin
            // drop done one edge after the strobe
            if (req_valid) begin
                if (req_is_write)
                    bus_write_done <= 1'b0;
                else
                    bus_read_done <= 1'b0;
            end
            if (rsp.valid) begin
                if (rsp.is_write) begin
                    bus_write_done <= 1'b1;
                end else begin
                    bus_read_data <= extended;   // held until the next load
                    bus_read_done <= 1'b1;
                end
            end
        end
    end

endmodule

/* source/soc_bus.sv */
module soc_bus
    import bus_types_pkg::*;
(
    input  logic     CLOCK_50,
    input  logic     KEY0,
    input  addr_t    bus_address,
    input  dword_t   bus_write_data,
    input  ls_type_e bus_ls_type,
    input  logic     bus_read_enable,
    input  logic     bus_write_enable,
    input  logic     ext_irq,
    output dword_t   bus_read_data,
    output logic     bus_read_done,
    output logic     bus_write_done,
    output logic     meip_interrupt,
    output logic     seip_interrupt
);
    decoded_req_if dec_req ();
    access_rsp_if  acc_rsp ();

    // stage 1
    address_decode i_address_decode (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_ls_type      (bus_ls_type),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .req              (dec_req.stage1)
    );

    // stage 2, RAM, timer compare and interrupt controller
    access_stage i_access_stage (
        .CLOCK_50       (CLOCK_50),
        .KEY0           (KEY0),
        .ext_irq        (ext_irq),
        .req            (dec_req.stage2),
        .rsp            (acc_rsp.stage2),
        .meip_interrupt (meip_interrupt),
        .seip_interrupt (seip_interrupt)
    );

    // stage 3 also watches the decoded valid to clear done early
    load_align i_load_align (
        .CLOCK_50       (CLOCK_50),
        .KEY0           (KEY0),
        .req_valid      (dec_req.valid),
        .req_is_write   (dec_req.is_write),
        .rsp            (acc_rsp.stage3),
        .bus_read_data  (bus_read_data),
        .bus_read_done  (bus_read_done),
        .bus_write_done (bus_write_done)
    );

endmodule

/* tb/clock_gen.sv */
module clock_gen #(
    parameter int HALF_PERIOD  = 2,
    parameter int RESET_CYCLES = 8
) (
    output logic CLOCK_50,
    output logic KEY0
);
    initial begin
        CLOCK_50 = 1'b0;
        forever #HALF_PERIOD CLOCK_50 = ~CLOCK_50;
    end

    initial begin
        KEY0 = 1'b0;                          // reset held from time zero
        repeat (RESET_CYCLES) @(posedge CLOCK_50);
        #1 KEY0 = 1'b1;
    end
endmodule

/* tb/tb_soc_bus.sv */
module tb_soc_bus
    import bus_types_pkg::*;
    import bus_map_pkg::*;
();
    localparam int RAM_ROUNDS      = 4;
    localparam int N_ACCESSES      = 2 + RAM_ROUNDS * 9 + 4 + 5 + 12 + 9;
    localparam int WATCHDOG_CYCLES = N_ACCESSES * 10 + 100;
    localparam int RAM_BYTES       = int'(RAM_SIZE);

    logic     CLOCK_50;
    logic     KEY0;
    addr_t    bus_address;
    dword_t   bus_write_data;
    ls_type_e bus_ls_type;
    logic     bus_read_enable;
    logic     bus_write_enable;
    logic     ext_irq;
    dword_t   bus_read_data;
    logic     bus_read_done;
    logic     bus_write_done;
    logic     meip_interrupt;
    logic     seip_interrupt;

    // reference state of RAM, timer and interrupt controller
    logic [7:0]  ram_model [RAM_BYTES];
    dword_t      mtimecmp_model;
    prio_t       prio_model [1:PLIC_NUM_SOURCES];
    logic [31:0] pending_model;
    logic [31:0] enable_model [2];
    prio_t       thresh_model [2];

    dword_t      expected_q [$];      // one entry per load in flight
    dword_t      expected_rd;
    logic        read_done_q = 1'b1;
    logic [31:0] lcg_state = 32'h2844;
    string       test_name = "none";
    int          errors = 0;
    int          errors_at_start;
    int          tests_run = 0;
    int          tests_ok = 0;

    ls_type_e store_types [4] = '{LS_B, LS_H, LS_W, LS_D};
    ls_type_e load_types [7]  = '{LS_B, LS_H, LS_W, LS_D, LS_BU, LS_HU, LS_WU};

    clock_gen i_clock_gen (.CLOCK_50(CLOCK_50), .KEY0(KEY0));

    soc_bus i_soc_bus (.*);

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic dword_t random64();
        return {next_random(), next_random()};
    endfunction

    function automatic int access_size(input ls_type_e t);
        case (t)
            LS_B, LS_BU: return 1;
            LS_H, LS_HU: return 2;
            LS_W, LS_WU: return 4;
            default:     return 8;
        endcase
    endfunction

    function automatic int aligned_offset(input ls_type_e t);
        return int'(next_random() & 32'h7) & ~(access_size(t) - 1);
    endfunction

    function automatic addr_t random_ram_word();
        logic [31:0] r;
        r = next_random();
        return RAM_BASE + {52'b0, r[8:0], 3'b000};
    endfunction

    function automatic logic in_ram(input addr_t addr);
        return addr >= RAM_BASE && addr < RAM_BASE + RAM_SIZE;
    endfunction

    function automatic logic is_priority(input addr_t addr);
        addr_t off;
        off = addr - PLIC_BASE;
        return off >= PLIC_PRIO_STRIDE && off <= PLIC_PRIO_STRIDE * PLIC_NUM_SOURCES &&
               off[1:0] == 2'b00;
    endfunction

    function automatic dword_t claim_model(input int ctx);
        return (pending_model[PLIC_SOURCE_ID] && enable_model[ctx][PLIC_SOURCE_ID]) ?
               64'd1 : 64'd0;
    endfunction

    // raw doubleword of the target shifted by offset and extended by type
    function automatic dword_t expected_load(input addr_t addr, input ls_type_e t);
        dword_t raw;
        dword_t sh;
        int     base;
        raw = '0;
        base = int'(addr - RAM_BASE) & ~7;
        if (in_ram(addr)) begin
            for (int i = 0; i < 8; i++)
                raw[i*8 +: 8] = ram_model[base + i];
        end else if (addr == MTIMECMP_ADDR) begin
            raw = mtimecmp_model;
        end else if (is_priority(addr)) begin
            raw = dword_t'(prio_model[int'((addr - PLIC_BASE) >> 2)]);
        end else if (addr == PLIC_PENDING) begin
            raw = dword_t'(pending_model);
        end else if (addr == PLIC_ENABLE) begin
            raw = dword_t'(enable_model[0]);
        end else if (addr == PLIC_ENABLE + PLIC_CTX_ENABLE_STRIDE) begin
            raw = dword_t'(enable_model[1]);
        end else if (addr == PLIC_THRESHOLD) begin
            raw = dword_t'(thresh_model[0]);
        end else if (addr == PLIC_THRESHOLD + PLIC_CTX_STRIDE) begin
            raw = dword_t'(thresh_model[1]);
        end else if (addr == PLIC_CLAIM) begin
            raw = claim_model(0);
        end else if (addr == PLIC_CLAIM + PLIC_CTX_STRIDE) begin
            raw = claim_model(1);
        end
        if (!in_ram(addr))
            raw = raw << (32 * int'(addr[2]));   // controller words sit in their half
        sh = raw >> (8 * int'(addr[2:0]));
        case (t)
            LS_B:    return {{56{sh[7]}}, sh[7:0]};
            LS_H:    return {{48{sh[15]}}, sh[15:0]};
            LS_W:    return {{32{sh[31]}}, sh[31:0]};
            LS_BU:   return {56'b0, sh[7:0]};
            LS_HU:   return {48'b0, sh[15:0]};
            LS_WU:   return {32'b0, sh[31:0]};
            default: return sh;
        endcase
    endfunction

    task automatic model_store(input addr_t addr, input dword_t data, input ls_type_e t);
        int base;
        base = int'(addr - RAM_BASE);
        if (in_ram(addr)) begin
            for (int i = 0; i < access_size(t); i++)
                ram_model[base + i] = data[i*8 +: 8];
        end else if (addr == MTIMECMP_ADDR) begin
            mtimecmp_model = data;
        end else if (is_priority(addr)) begin
            prio_model[int'((addr - PLIC_BASE) >> 2)] = data[2:0];
        end else if (addr == PLIC_ENABLE) begin
            enable_model[0] = data[31:0];
        end else if (addr == PLIC_ENABLE + PLIC_CTX_ENABLE_STRIDE) begin
            enable_model[1] = data[31:0];
        end else if (addr == PLIC_THRESHOLD) begin
            thresh_model[0] = data[2:0];
        end else if (addr == PLIC_THRESHOLD + PLIC_CTX_STRIDE) begin
            thresh_model[1] = data[2:0];
        end
    endtask

    // one strobe, then wait for the done level to fall and rise again
    task automatic run_access(input logic write, input addr_t addr, input dword_t data,
                              input ls_type_e t);
        int   cycles;
        int   low_cycles;
        logic done;
        bus_address    = addr;
        bus_write_data = data;
        bus_ls_type    = t;
        if (write)
            bus_write_enable = 1'b1;
        else
            bus_read_enable = 1'b1;
        @(posedge CLOCK_50);                  // E0 samples the strobe
        #1;
        bus_read_enable  = 1'b0;
        bus_write_enable = 1'b0;
        cycles     = 0;
        low_cycles = 0;
        done       = 1'b0;
        while (low_cycles == 0 || !done) begin
            @(posedge CLOCK_50);
            #1;
            cycles++;
            done = write ? bus_write_done : bus_read_done;
            if (!done)
                low_cycles++;
        end
        assert (cycles == 2 && low_cycles == 1) else begin
            $display("%s: done was low for %0d cycles and came back %0d edges after the strobe",
                     test_name, low_cycles, cycles);
            errors++;
        end
    endtask

    task automatic bus_store(input addr_t addr, input dword_t data, input ls_type_e t);
        model_store(addr, data, t);
        run_access(1'b1, addr, data, t);
    endtask

    task automatic bus_load(input addr_t addr, input ls_type_e t);
        expected_q.push_back(expected_load(addr, t));
        if (addr == PLIC_CLAIM && claim_model(0) != 64'd0)
            pending_model[PLIC_SOURCE_ID] = 1'b0;   // claim clears the source
        if (addr == PLIC_CLAIM + PLIC_CTX_STRIDE && claim_model(1) != 64'd0)
            pending_model[PLIC_SOURCE_ID] = 1'b0;
        run_access(1'b0, addr, '0, t);
    endtask

    task automatic check_value(input string what, input dword_t expected, input dword_t actual);
        assert (actual === expected) else begin
            $display("Fail %s %s: expected %h, actual %h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic raise_irq();
        ext_irq = 1'b1;
        pending_model[PLIC_SOURCE_ID] = 1'b1;
        repeat (3) @(posedge CLOCK_50);       // edge detect needs a cycle before pending
        #1;
    endtask

    task automatic lower_irq();
        ext_irq = 1'b0;
        repeat (2) @(posedge CLOCK_50);
        #1;
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        @(negedge CLOCK_50);                  // last load reaches the compare process
        @(posedge CLOCK_50);
        #1;
        tests_run++;
        if (errors == errors_at_start) begin
            tests_ok++;
            $display("%s: ok", test_name);
        end else begin
            $display("%s: %0d errors", test_name, errors - errors_at_start);
        end
    endtask

    // compares each load on the cycle its done level comes back
    always @(negedge CLOCK_50) begin
        if (KEY0 && bus_read_done && !read_done_q && expected_q.size() > 0) begin
            expected_rd = expected_q.pop_front();
            assert (bus_read_data === expected_rd) else begin
                $display("Fail %s: expected %h, actual %h", test_name, expected_rd, bus_read_data);
                errors++;
            end
        end
        read_done_q = bus_read_done;
    end

    initial begin
        addr_t word;
        bus_address      = '0;
        bus_write_data   = '0;
        bus_ls_type      = LS_D;
        bus_read_enable  = 1'b0;
        bus_write_enable = 1'b0;
        ext_irq          = 1'b0;
        mtimecmp_model   = MTIMECMP_RESET;
        pending_model    = '0;
        enable_model     = '{32'h0, 32'h0};
        thresh_model     = '{3'h0, 3'h0};
        for (int i = 1; i <= PLIC_NUM_SOURCES; i++)
            prio_model[i] = '0;
        wait (KEY0);

        begin_test("reset_latency");
        check_value("read done", 64'd1, dword_t'(bus_read_done));
        check_value("write done", 64'd1, dword_t'(bus_write_done));
        check_value("read data", 64'd0, bus_read_data);
        check_value("meip", 64'd0, dword_t'(meip_interrupt));
        check_value("seip", 64'd0, dword_t'(seip_interrupt));
        bus_store(RAM_BASE, random64(), LS_D);
        bus_load(RAM_BASE, LS_D);
        end_test();

        begin_test("ram_round_trip");
        for (int r = 0; r < RAM_ROUNDS; r++) begin
            word = random_ram_word();
            bus_store(word, random64(), LS_D);
            bus_store(word + addr_t'(aligned_offset(store_types[r])), random64(),
                      store_types[r]);
            for (int k = 0; k < 7; k++)
                bus_load(word + addr_t'(aligned_offset(load_types[k])), load_types[k]);
        end
        end_test();

        begin_test("byte_lanes");
        word = RAM_BASE + 64'hff8;            // last doubleword of the RAM
        bus_store(word, 64'h0123_4567_89ab_cdef, LS_D);
        bus_store(word + 64'd3, 64'h5a, LS_B);
        bus_store(word + 64'd6, 64'hbeef, LS_H);
        bus_load(word, LS_D);
        end_test();

        begin_test("timer_unmapped");
        bus_load(MTIMECMP_ADDR, LS_D);
        bus_store(MTIMECMP_ADDR, random64(), LS_D);
        bus_load(MTIMECMP_ADDR, LS_D);
        bus_load(RAM_BASE + RAM_SIZE, LS_D);  // just past the RAM
        bus_store(64'h0000_0000_1000_0008, random64(), LS_D);
        end_test();

        begin_test("plic_registers");
        bus_store(PLIC_BASE + 64'd8, 64'hff, LS_W);
        bus_load(PLIC_BASE + 64'd8, LS_WU);
        bus_store(PLIC_ENABLE, random64(), LS_W);
        bus_load(PLIC_ENABLE, LS_WU);
        bus_store(PLIC_ENABLE + PLIC_CTX_ENABLE_STRIDE, random64(), LS_W);
        bus_load(PLIC_ENABLE + PLIC_CTX_ENABLE_STRIDE, LS_WU);
        bus_store(PLIC_THRESHOLD, 64'h1d, LS_W);
        bus_load(PLIC_THRESHOLD, LS_WU);
        bus_store(PLIC_THRESHOLD + PLIC_CTX_STRIDE, 64'hfe, LS_W);
        bus_load(PLIC_THRESHOLD + PLIC_CTX_STRIDE, LS_WU);
        bus_store(PLIC_PENDING, 64'hffff_ffff, LS_W);
        bus_load(PLIC_PENDING, LS_WU);
        end_test();

        begin_test("claim_flow");
        bus_store(PLIC_ENABLE, 64'h2, LS_W);
        bus_store(PLIC_ENABLE + PLIC_CTX_ENABLE_STRIDE, 64'h0, LS_W);
        raise_irq();
        check_value("meip raised", 64'd1, dword_t'(meip_interrupt));
        check_value("seip idle", 64'd0, dword_t'(seip_interrupt));
        bus_load(PLIC_CLAIM, LS_WU);
        check_value("meip after claim", 64'd0, dword_t'(meip_interrupt));
        bus_load(PLIC_PENDING, LS_WU);
        bus_load(PLIC_CLAIM, LS_WU);
        lower_irq();
        bus_store(PLIC_ENABLE, 64'h0, LS_W);
        bus_store(PLIC_ENABLE + PLIC_CTX_ENABLE_STRIDE, 64'h2, LS_W);
        raise_irq();
        check_value("seip raised", 64'd1, dword_t'(seip_interrupt));
        check_value("meip idle", 64'd0, dword_t'(meip_interrupt));
        bus_load(PLIC_CLAIM + PLIC_CTX_STRIDE, LS_WU);
        check_value("seip after claim", 64'd0, dword_t'(seip_interrupt));
        bus_load(PLIC_CLAIM + PLIC_CTX_STRIDE, LS_WU);
        lower_irq();
        end_test();

        $display("%0d of %0d tests ok, %0d errors", tests_ok, tests_run, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    // bounds the run by the number of bus accesses
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLOCK_50);
        $display("watchdog expired, the bus stopped answering during %s", test_name);
        $display("tests failed");
        $finish;
    end

endmodule

/* project.f */
source/bus_types_pkg.sv
source/bus_map_pkg.sv
source/decoded_req_if.sv
source/access_rsp_if.sv
source/ram_bank.sv
source/plic.sv
source/address_decode.sv
source/access_stage.sv
source/load_align.sv
source/soc_bus.sv
tb/clock_gen.sv
tb/tb_soc_bus.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_soc_bus -f project.f -o sim_soc_bus
./obj_dir/sim_soc_bus | tee sim.log

if ! grep -qx "all tests passed" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
